/* biquad_datapath.sv */
/*
 * Direct form I biquad datapath with one shared multiplier. The sequencer
 * picks the term each cycle; the output step scales, saturates and shifts.
 */

`default_nettype none

`include "iir_consts.svh"

module biquad_datapath (
  input  wire                                clk,
  input  wire                                rst,
  input  wire                                enable,
  input  wire                                bypass,
  input  wire  signed [`IIR_COEF_WIDTH-1:0]  b0,
  input  wire  signed [`IIR_COEF_WIDTH-1:0]  b1,
  input  wire  signed [`IIR_COEF_WIDTH-1:0]  b2,
  input  wire  signed [`IIR_COEF_WIDTH-1:0]  a1,
  input  wire  signed [`IIR_COEF_WIDTH-1:0]  a2,
  input  wire  signed [`IIR_WAVE_WIDTH-1:0]  x,
  input  iir_pkg::biquad_ctrl_t              ctrl,
  output logic signed [`IIR_WAVE_WIDTH-1:0]  y
);

  localparam int AW_C = `IIR_ACC_WIDTH;
  localparam int WW_C = `IIR_WAVE_WIDTH;
  localparam logic signed [AW_C-1:0] SAT_MAX_C = (AW_C'(1) << (WW_C - 1)) - 1;
  localparam logic signed [AW_C-1:0] SAT_MIN_C = -(AW_C'(1) << (WW_C - 1));

  logic signed [`IIR_COEF_WIDTH-1:0] coef;
  logic signed [WW_C-1:0]            operand;
  logic signed [AW_C-1:0]            product;
  logic                              subtract;
  logic signed [AW_C-1:0]            acc;
  logic signed [AW_C-1:0]            scaled;
  logic signed [WW_C-1:0]            y_sat;
  logic signed [WW_C-1:0]            x1, x2, y1, y2; // sample history

  ////////////////////////////////////////
  // shared multiplier
  ////////////////////////////////////////
  always_comb begin
    subtract = 1'b0;
    case (ctrl.term)
      iir_pkg::TERM_B0X0: {coef, operand} = {b0, x};
      iir_pkg::TERM_B1X1: {coef, operand} = {b1, x1};
      iir_pkg::TERM_B2X2: {coef, operand} = {b2, x2};
      iir_pkg::TERM_A1Y1: begin
        {coef, operand} = {a1, y1};
        subtract        = 1'b1; // feedback terms enter negated
      end
      iir_pkg::TERM_A2Y2: begin
        {coef, operand} = {a2, y2};
        subtract        = 1'b1;
      end
      default: {coef, operand} = '0;
    endcase
  end

  assign product = AW_C'(coef * operand); // sign extended to the acc width

  always_ff @(posedge clk) begin
    if (ctrl.mac_en) begin
      if (ctrl.acc_clear) acc <= product;
      else if (subtract)  acc <= acc - product;
      else                acc <= acc + product;
    end
  end

  // back to sample scale, then clamp
  assign scaled = acc >>> `IIR_Q_BITS;
  assign y_sat  = (scaled > SAT_MAX_C) ? SAT_MAX_C[WW_C-1:0] :
                  (scaled < SAT_MIN_C) ? SAT_MIN_C[WW_C-1:0] : scaled[WW_C-1:0];

  ////////////////////////////////////////
  // output and history
  ////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (rst || !enable) begin
      y  <= '0;
      x1 <= '0;
      x2 <= '0;
      y1 <= '0;
      y2 <= '0;
    end else if (ctrl.out_load) begin
      y  <= bypass ? x : y_sat; // bypass only touches the output
      x1 <= x;
      x2 <= x1;
      y1 <= y_sat;
      y2 <= y1;
    end
  end

endmodule

`default_nettype wire

/* biquad_sequencer.sv */
/*
 * Biquad sequencer. A tick starts five MAC steps (B0 to A2) and an output
 * step; y_valid follows the output step by one cycle, 7 cycles after tick.
 */

`default_nettype none

module biquad_sequencer (
  input  wire                          clk,
  input  wire                          rst,
  input  wire                          tick,
  output iir_pkg::biquad_ctrl_t        ctrl,
  output logic                         y_valid
);

  iir_pkg::seq_state_e state;
  iir_pkg::seq_state_e state_nxt;

  always_ff @(posedge clk) begin
    if (rst) begin
      state   <= iir_pkg::SEQ_IDLE;
      y_valid <= 1'b0;
    end else begin
      state   <= state_nxt;
      y_valid <= (state == iir_pkg::SEQ_OUT); // y is loaded in the same edge
    end
  end

  ////////////////////////////////////////
  // next state and per-step control
  ////////////////////////////////////////
  always_comb begin
    state_nxt = state;
    ctrl      = '0;
    case (state)
      iir_pkg::SEQ_IDLE: if (tick) state_nxt = iir_pkg::SEQ_B0;
      iir_pkg::SEQ_B0: begin
        ctrl.mac_en    = 1'b1;
        ctrl.acc_clear = 1'b1; // fresh sum per sample
        ctrl.term      = iir_pkg::TERM_B0X0;
        state_nxt      = iir_pkg::SEQ_B1;
      end
      iir_pkg::SEQ_B1: begin
        ctrl.mac_en = 1'b1;
        ctrl.term   = iir_pkg::TERM_B1X1;
        state_nxt   = iir_pkg::SEQ_B2;
      end
      iir_pkg::SEQ_B2: begin
        ctrl.mac_en = 1'b1;
        ctrl.term   = iir_pkg::TERM_B2X2;
        state_nxt   = iir_pkg::SEQ_A1;
      end
      iir_pkg::SEQ_A1: begin
        ctrl.mac_en = 1'b1;
        ctrl.term   = iir_pkg::TERM_A1Y1;
        state_nxt   = iir_pkg::SEQ_A2;
      end
      iir_pkg::SEQ_A2: begin
        ctrl.mac_en = 1'b1;
        ctrl.term   = iir_pkg::TERM_A2Y2;
        state_nxt   = iir_pkg::SEQ_OUT;
      end
      iir_pkg::SEQ_OUT: begin
        ctrl.out_load = 1'b1;
        state_nxt     = iir_pkg::SEQ_IDLE;
      end
      default: state_nxt = iir_pkg::SEQ_IDLE;
    endcase
  end

endmodule

`default_nettype wire

/* filelist.f */
+incdir+.
iir_pkg.sv
iir_apb_regs.sv
sample_enable_timer.sv
saw_oscillator.sv
biquad_sequencer.sv
biquad_datapath.sv
iir_biquad_system.sv
iir_checker.sv
tb_iir_biquad_system.sv

/* iir_apb_regs.sv */
/*
 * APB3 register block for the biquad subsystem. No wait states; bad
 * addresses answer with pslverr and read zero. Drives the config struct.
 */

`default_nettype none

`include "iir_consts.svh"

module iir_apb_regs (
  input  wire                               clk,
  input  wire                               rst,
  input  wire  [`IIR_APB_ADDR_WIDTH-1 : 0]  paddr,
  input  wire                               psel,
  input  wire                               penable,
  input  wire                               pwrite,
  input  wire  [`IIR_APB_DATA_WIDTH-1 : 0]  pwdata,
  output logic                              pready,
  output logic [`IIR_APB_DATA_WIDTH-1 : 0]  prdata,
  output logic                              pslverr,
  output iir_pkg::iir_cfg_t                 cfg
);

  localparam int DW_C = `IIR_APB_DATA_WIDTH;
  localparam int WW_C = `IIR_WAVE_WIDTH;
  localparam int CW_C = `IIR_COEF_WIDTH;
  localparam logic [`IIR_COUNTER_WIDTH-1:0] MIN_PERIOD_C = `IIR_MIN_PERIOD;
  localparam logic signed [CW_C-1:0] COEF_ONE_C = 1 << `IIR_Q_BITS; // 1.0

  logic                            access;
  logic                            addr_err;
  iir_pkg::iir_reg_e               reg_addr;
  logic [`IIR_COUNTER_WIDTH-1:0]   wr_period;

  assign access    = psel && penable;
  assign reg_addr  = iir_pkg::iir_reg_e'(paddr[4:2]);
  assign addr_err  = (paddr[1:0] != 2'b00) || (paddr[`IIR_APB_ADDR_WIDTH-1:5] != '0);
  assign wr_period = (pwdata[`IIR_COUNTER_WIDTH-1:0] < MIN_PERIOD_C) ?
                     MIN_PERIOD_C : pwdata[`IIR_COUNTER_WIDTH-1:0]; // clamp short periods

  assign pready  = access; // never stalls
  assign pslverr = access && addr_err;

  ////////////////////////////////////////
  // register writes, access phase only
  ////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (rst) begin
      cfg        <= '0;
      cfg.period <= MIN_PERIOD_C;
      cfg.b0     <= COEF_ONE_C; // pass-through until programmed
    end else if (access && pwrite && !addr_err) begin
      case (reg_addr)
        iir_pkg::REG_CTRL: begin
          cfg.enable <= pwdata[0];
          cfg.bypass <= pwdata[1];
        end
        iir_pkg::REG_PERIOD: cfg.period <= wr_period;
        iir_pkg::REG_STEP:   cfg.step   <= pwdata[WW_C-1:0];
        iir_pkg::REG_B0:     cfg.b0     <= pwdata[CW_C-1:0];
        iir_pkg::REG_B1:     cfg.b1     <= pwdata[CW_C-1:0];
        iir_pkg::REG_B2:     cfg.b2     <= pwdata[CW_C-1:0];
        iir_pkg::REG_A1:     cfg.a1     <= pwdata[CW_C-1:0];
        iir_pkg::REG_A2:     cfg.a2     <= pwdata[CW_C-1:0];
      endcase
    end
  end

  // readback, signed fields come back sign extended
  always_comb begin
    prdata = '0;
    if (access && !addr_err) begin
      case (reg_addr)
        iir_pkg::REG_CTRL:   prdata[1:0] = {cfg.bypass, cfg.enable};
        iir_pkg::REG_PERIOD: prdata[`IIR_COUNTER_WIDTH-1:0] = cfg.period;
        iir_pkg::REG_STEP:   prdata = {{(DW_C-WW_C){cfg.step[WW_C-1]}}, cfg.step};
        iir_pkg::REG_B0:     prdata = {{(DW_C-CW_C){cfg.b0[CW_C-1]}}, cfg.b0};
        iir_pkg::REG_B1:     prdata = {{(DW_C-CW_C){cfg.b1[CW_C-1]}}, cfg.b1};
        iir_pkg::REG_B2:     prdata = {{(DW_C-CW_C){cfg.b2[CW_C-1]}}, cfg.b2};
        iir_pkg::REG_A1:     prdata = {{(DW_C-CW_C){cfg.a1[CW_C-1]}}, cfg.a1};
        iir_pkg::REG_A2:     prdata = {{(DW_C-CW_C){cfg.a2[CW_C-1]}}, cfg.a2};
      endcase
    end
  end

endmodule

`default_nettype wire

/* iir_biquad_system.sv */
/*
 * Biquad test subsystem: APB3 registers, sample timer, sawtooth source,
 * sequencer and datapath. y is held between y_valid pulses.
 */

`default_nettype none

`include "iir_consts.svh"

module iir_biquad_system (
  input  wire                                clk,
  input  wire                                rst,
  input  wire  [`IIR_APB_ADDR_WIDTH-1 : 0]   paddr,
  input  wire                                psel,
  input  wire                                penable,
  input  wire                                pwrite,
  input  wire  [`IIR_APB_DATA_WIDTH-1 : 0]   pwdata,
  output logic                               pready,
  output logic [`IIR_APB_DATA_WIDTH-1 : 0]   prdata,
  output logic                               pslverr,
  output logic signed [`IIR_WAVE_WIDTH-1:0]  y,
  output logic                               y_valid
);

  iir_pkg::iir_cfg_t                 cfg;
  iir_pkg::biquad_ctrl_t             ctrl;
  logic                              tick;
  logic signed [`IIR_WAVE_WIDTH-1:0] x;

  iir_apb_regs regs_i (
    .clk     ( clk     ), // input
    .rst     ( rst     ), // input
    .paddr   ( paddr   ), // input
    .psel    ( psel    ), // input
    .penable ( penable ), // input
    .pwrite  ( pwrite  ), // input
    .pwdata  ( pwdata  ), // input
    .pready  ( pready  ), // output
    .prdata  ( prdata  ), // output
    .pslverr ( pslverr ), // output
    .cfg     ( cfg     )  // output
  );

  sample_enable_timer timer_i (
    .clk    ( clk        ),
    .rst    ( rst        ),
    .enable ( cfg.enable ),
    .period ( cfg.period ),
    .tick   ( tick       )  // output
  );

  saw_oscillator osc_i (
    .clk    ( clk        ),
    .rst    ( rst        ),
    .enable ( cfg.enable ),
    .tick   ( tick       ),
    .step   ( cfg.step   ),
    .x      ( x          )  // output
  );

  biquad_sequencer seq_i (
    .clk     ( clk     ),
    .rst     ( rst     ),
    .tick    ( tick    ),
    .ctrl    ( ctrl    ), // output
    .y_valid ( y_valid )  // output
  );

  biquad_datapath dp_i (
    .clk    ( clk        ),
    .rst    ( rst        ),
    .enable ( cfg.enable ),
    .bypass ( cfg.bypass ),
    .b0     ( cfg.b0     ),
    .b1     ( cfg.b1     ),
    .b2     ( cfg.b2     ),
    .a1     ( cfg.a1     ),
    .a2     ( cfg.a2     ),
    .x      ( x          ),
    .ctrl   ( ctrl       ),
    .y      ( y          )  // output
  );

endmodule

`default_nettype wire

/* iir_checker.sv */
/*
 * Concurrent assertions on the biquad sequencer, attached by bind.
 * Covers y_valid width, tick to y_valid latency and idle on reset.
 */

`default_nettype none

module iir_checker (
  input  wire        clk,
  input  wire        rst,
  input  wire        tick,
  input  wire        y_valid,
  input  wire  [2:0] state
);

  a_valid_single: assert property (@(posedge clk) disable iff (rst) y_valid |=> !y_valid)
    else $error("y_valid held high for two cycles");

  // five MAC steps and the output step
  a_tick_latency: assert property (@(posedge clk) disable iff (rst) tick |-> ##7 y_valid)
    else $error("y_valid missing 7 cycles after tick");

  a_tick_in_idle: assert property (@(posedge clk) disable iff (rst)
      tick |-> state == iir_pkg::SEQ_IDLE)
    else $error("tick arrived while the sequencer was busy");

  a_idle_on_rst: assert property (@(posedge clk) rst |=> state == iir_pkg::SEQ_IDLE)
    else $error("sequencer not idle after reset");

endmodule

bind biquad_sequencer iir_checker chk_i (
  .clk     ( clk     ),
  .rst     ( rst     ),
  .tick    ( tick    ),
  .y_valid ( y_valid ),
  .state   ( state   )
);

`default_nettype wire

/* iir_consts.svh */
/*
 * Widths and limits shared by the biquad test subsystem.
 * Included by the package, the RTL and the testbench.
 */

`ifndef IIR_CONSTS_SVH
`define IIR_CONSTS_SVH

// sample and coefficient formats
`define IIR_WAVE_WIDTH      16  // signed samples
`define IIR_COEF_WIDTH      18  // signed coefficients
`define IIR_Q_BITS          14  // fraction bits of a coefficient
`define IIR_ACC_WIDTH       40  // headroom for five products

// register bus
`define IIR_APB_ADDR_WIDTH  8
`define IIR_APB_DATA_WIDTH  32

// sample timer
`define IIR_COUNTER_WIDTH   16
`define IIR_MIN_PERIOD      8   // sequencer needs 7 cycles per sample

`endif

/* iir_pkg.sv */
/*
 * Types shared by the biquad subsystem: register map, sequencer states,
 * datapath terms and the configuration and control structs.
 */

`default_nettype none

`include "iir_consts.svh"

package iir_pkg;

  // word addresses, byte offset is 4x
  typedef enum logic [2:0] {
    REG_CTRL   = 3'd0,
    REG_PERIOD = 3'd1,
    REG_STEP   = 3'd2,
    REG_B0     = 3'd3,
    REG_B1     = 3'd4,
    REG_B2     = 3'd5,
    REG_A1     = 3'd6,
    REG_A2     = 3'd7
  } iir_reg_e;

  typedef enum logic [2:0] {
    SEQ_IDLE,
    SEQ_B0,
    SEQ_B1,
    SEQ_B2,
    SEQ_A1,
    SEQ_A2,
    SEQ_OUT
  } seq_state_e;

  typedef enum logic [2:0] {
    TERM_B0X0,
    TERM_B1X1,
    TERM_B2X2,
    TERM_A1Y1,
    TERM_A2Y2
  } mac_term_e;

  typedef struct packed {
    logic                                  enable;
    logic                                  bypass;
    logic         [`IIR_COUNTER_WIDTH-1:0] period;
    logic signed  [`IIR_WAVE_WIDTH-1:0]    step;
    logic signed  [`IIR_COEF_WIDTH-1:0]    b0;
    logic signed  [`IIR_COEF_WIDTH-1:0]    b1;
    logic signed  [`IIR_COEF_WIDTH-1:0]    b2;
    logic signed  [`IIR_COEF_WIDTH-1:0]    a1;
    logic signed  [`IIR_COEF_WIDTH-1:0]    a2;
  } iir_cfg_t;

  typedef struct packed {
    logic      mac_en;     // accumulate this cycle
    logic      acc_clear;  // first term overwrites the sum
    mac_term_e term;
    logic      out_load;   // saturate, load y, shift history
  } biquad_ctrl_t;

endpackage

`default_nettype wire

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the biquad testbench with Verilator, runs it and checks the log.
set -eo pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f filelist.f \
  --top-module tb_iir_biquad_system -o tb_iir_biquad_system

./obj_dir/tb_iir_biquad_system | tee sim.log

if grep -q "Done: errors found" sim.log; then
  echo "simulation failed"
  exit 1
fi
echo "simulation passed"

/* sample_enable_timer.sv */
/*
 * Sampling enable. Counts 0 to period-1 and pulses tick as the count
 * wraps, so the first tick lands period cycles after enable rises.
 */

`default_nettype none

`include "iir_consts.svh"

module sample_enable_timer (
  input  wire                               clk,
  input  wire                               rst,
  input  wire                               enable,
  input  wire  [`IIR_COUNTER_WIDTH-1 : 0]   period,
  output logic                              tick
);

  logic [`IIR_COUNTER_WIDTH-1:0] count;

  always_ff @(posedge clk) begin
    if (rst || !enable) begin
      count <= '0; // held while disabled
      tick  <= 1'b0;
    end else if (count == period - 1'b1) begin
      count <= '0;
      tick  <= 1'b1; // high in the cycle after the wrap
    end else begin
      count <= count + 1'b1;
      tick  <= 1'b0;
    end
  end

endmodule

`default_nettype wire

/* saw_oscillator.sv */
/*
 * Sawtooth source. On each tick the current phase is presented on x and
 * the phase then advances by step, wrapping at the wave width.
 */

`default_nettype none

`include "iir_consts.svh"

module saw_oscillator (
  input  wire                                clk,
  input  wire                                rst,
  input  wire                                enable,
  input  wire                                tick,
  input  wire  signed [`IIR_WAVE_WIDTH-1:0]  step,
  output logic signed [`IIR_WAVE_WIDTH-1:0]  x
);

  logic signed [`IIR_WAVE_WIDTH-1:0] phase;

  always_ff @(posedge clk) begin
    if (rst || !enable) begin
      phase <= '0; // restart from zero phase
      x     <= '0;
    end else if (tick) begin
      x     <= phase;
      phase <= phase + step; // two's complement wrap
    end
  end

endmodule

`default_nettype wire

/* tb_iir_biquad_system.sv */
/*
 * Testbench for the biquad subsystem. Programs the registers over APB3,
 * runs a table of filter setups and checks each y against a biquad model.
 */

`default_nettype none

`include "iir_consts.svh"

module tb_iir_biquad_system;

  localparam int QB       = `IIR_Q_BITS;
  localparam int WAVE_MAX = (1 << (`IIR_WAVE_WIDTH - 1)) - 1;
  localparam int WAVE_MIN = -(1 << (`IIR_WAVE_WIDTH - 1));
  localparam int NUM_ROWS = 6;

  typedef struct packed {
    logic                                 bypass;
    logic        [`IIR_COUNTER_WIDTH-1:0] period;
    logic signed [`IIR_WAVE_WIDTH-1:0]    step;     // zero picks a random step
    logic signed [31:0]                   b0;
    logic signed [31:0]                   b1;
    logic signed [31:0]                   b2;
    logic signed [31:0]                   a1;
    logic signed [31:0]                   a2;
    logic        [7:0]                    count;    // samples to check
    logic                                 need_sat; // must clamp both ways
  } row_t;

  // Q14 coefficients, 16384 is 1.0
  localparam row_t ROWS [NUM_ROWS] = '{
    '{1'b1, 16'd8,  16'sd0,     32'sd8192,  32'sd4096,  32'sd0,    -32'sd3000,  32'sd0,
      8'd20, 1'b0},
    '{1'b0, 16'd10, 16'sd0,     32'sd8192,  32'sd0,     32'sd0,     32'sd0,     32'sd0,
      8'd20, 1'b0},
    '{1'b0, 16'd9,  16'sd0,     32'sd0,     32'sd16384, 32'sd0,     32'sd0,     32'sd0,
      8'd16, 1'b0},
    '{1'b0, 16'd12, 16'sh2A00,  32'sd16384, 32'sd0,     32'sd0,    -32'sd26000, 32'sd13000,
      8'd40, 1'b0},
    '{1'b0, 16'd8,  16'sh1234,  32'sd65536, 32'sd0,     32'sd0,    -32'sd4096,  32'sd2048,
      8'd40, 1'b1},
    '{1'b0, 16'd16, 16'sd0,     32'sd5000, -32'sd7000,  32'sd3000, -32'sd12000, 32'sd5000,
      8'd25, 1'b0}
  };

  logic                              clk;
  logic                              rst;
  logic [`IIR_APB_ADDR_WIDTH-1:0]    paddr;
  logic                              psel;
  logic                              penable;
  logic                              pwrite;
  logic [`IIR_APB_DATA_WIDTH-1:0]    pwdata;
  logic                              pready;
  logic [`IIR_APB_DATA_WIDTH-1:0]    prdata;
  logic                              pslverr;
  logic signed [`IIR_WAVE_WIDTH-1:0] y;
  logic                              y_valid;

  integer seed = 18395;
  int     errors = 0;
  int     checks = 0;
  int     tests = 0;
  int     mx1, mx2, my1, my2; // model history
  int     sat_hi, sat_lo;

  iir_biquad_system dut_i (
    .clk     ( clk     ),
    .rst     ( rst     ),
    .paddr   ( paddr   ),
    .psel    ( psel    ),
    .penable ( penable ),
    .pwrite  ( pwrite  ),
    .pwdata  ( pwdata  ),
    .pready  ( pready  ),
    .prdata  ( prdata  ),
    .pslverr ( pslverr ),
    .y       ( y       ),
    .y_valid ( y_valid )
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  ////////////////////////////////////////
  // helpers
  ////////////////////////////////////////
  function automatic logic [7:0] byte_addr(input int word);
    return 8'(word * 4);
  endfunction

  task automatic check_value(input int got, input int exp, input string what);
    checks++;
    if (got != exp) begin
      errors++;
      $display("Fail %0t: %s, got %0d expected %0d", $time, what, got, exp);
    end
  endtask

  task automatic write_reg(input logic [7:0] addr, input logic [31:0] data);
    @(posedge clk);
    psel    <= 1'b1; // setup phase
    penable <= 1'b0;
    pwrite  <= 1'b1;
    paddr   <= addr;
    pwdata  <= data;
    @(posedge clk);
    penable <= 1'b1;
    @(posedge clk);
    psel    <= 1'b0;
    penable <= 1'b0;
  endtask

  task automatic read_reg(input logic [7:0] addr, output logic [31:0] data, output logic err);
    @(posedge clk);
    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= 1'b0;
    paddr   <= addr;
    @(posedge clk);
    penable <= 1'b1;
    @(negedge clk);
    data = prdata; // mid access phase
    err  = pslverr;
    check_value(pready, 1, "pready in access phase");
    @(posedge clk);
    psel    <= 1'b0;
    penable <= 1'b0;
  endtask

  task automatic wait_valid(input int limit, output logic seen);
    int n;
    seen = 1'b0;
    for (n = 0; n < limit && !seen; n++) begin
      @(negedge clk);
      seen = y_valid;
    end
  endtask

  // direct form I with Q14 scaling and clamp to the sample range
  task automatic model_sample(input int r, input int x0, output int y_exp);
    longint acc;
    longint s;
    int     y_f;
    acc = longint'(ROWS[r].b0) * x0 + longint'(ROWS[r].b1) * mx1
        + longint'(ROWS[r].b2) * mx2 - longint'(ROWS[r].a1) * my1
        - longint'(ROWS[r].a2) * my2;
    s = acc >>> QB;
    if (s > WAVE_MAX)
      y_f = WAVE_MAX;
    else if (s < WAVE_MIN)
      y_f = WAVE_MIN;
    else
      y_f = int'(s);
    y_exp = ROWS[r].bypass ? x0 : y_f; // history keeps the filtered value
    mx2 = mx1;
    mx1 = x0;
    my2 = my1;
    my1 = y_f;
  endtask

  function automatic longint run_limit();
    longint total;
    int     r;
    total = 400000; // register, rate and disable tests
    for (r = 0; r < NUM_ROWS; r++)
      total += (longint'(ROWS[r].count) + 2) * longint'(ROWS[r].period) * 100;
    return total;
  endfunction

  ////////////////////////////////////////
  // tests
  ////////////////////////////////////////
  task automatic register_access();
    logic [31:0] rd;
    logic        err;
    int          e0;
    int          i;
    e0 = errors;
    write_reg(byte_addr(iir_pkg::REG_CTRL), 32'd2);
    read_reg(byte_addr(iir_pkg::REG_CTRL), rd, err);
    check_value(rd, 2, "ctrl readback");
    check_value(err, 0, "pslverr on a mapped read");
    write_reg(byte_addr(iir_pkg::REG_PERIOD), 32'd3);
    read_reg(byte_addr(iir_pkg::REG_PERIOD), rd, err);
    check_value(rd, `IIR_MIN_PERIOD, "short period clamped");
    write_reg(byte_addr(iir_pkg::REG_PERIOD), 32'd200);
    read_reg(byte_addr(iir_pkg::REG_PERIOD), rd, err);
    check_value(rd, 200, "period readback");
    write_reg(byte_addr(iir_pkg::REG_STEP), -32'sd1234);
    read_reg(byte_addr(iir_pkg::REG_STEP), rd, err);
    check_value(rd, -1234, "step readback sign extended");
    for (i = iir_pkg::REG_B0; i <= iir_pkg::REG_A2; i++) begin
      write_reg(byte_addr(i), (i - 5) * 25000 + 111);
      read_reg(byte_addr(i), rd, err);
      check_value(rd, (i - 5) * 25000 + 111, $sformatf("coefficient %0d readback", i));
    end
    write_reg(8'h21, 32'd3); // unaligned, must not touch ctrl
    read_reg(byte_addr(iir_pkg::REG_CTRL), rd, err);
    check_value(rd, 2, "ctrl after unaligned write");
    read_reg(8'h20, rd, err);
    check_value(err, 1, "pslverr on unmapped read");
    check_value(rd, 0, "unmapped read data");
    read_reg(8'h06, rd, err);
    check_value(err, 1, "pslverr on unaligned read");
    check_value(rd, 0, "unaligned read data");
    tests++;
    $display("register access: %0d errors", errors - e0);
  endtask

  task automatic run_row(input int r);
    logic signed [`IIR_WAVE_WIDTH-1:0] step;
    logic signed [`IIR_WAVE_WIDTH-1:0] x0;
    logic                              ok;
    int                                y_exp;
    int                                k;
    int                                e0;
    e0   = errors;
    step = (ROWS[r].step != 0) ? ROWS[r].step : 16'($random(seed));
    write_reg(byte_addr(iir_pkg::REG_CTRL), 32'd0);
    repeat (10) @(posedge clk); // let a sample in flight drain
    write_reg(byte_addr(iir_pkg::REG_PERIOD), 32'(ROWS[r].period));
    write_reg(byte_addr(iir_pkg::REG_STEP), 32'(step));
    write_reg(byte_addr(iir_pkg::REG_B0), ROWS[r].b0);
    write_reg(byte_addr(iir_pkg::REG_B1), ROWS[r].b1);
    write_reg(byte_addr(iir_pkg::REG_B2), ROWS[r].b2);
    write_reg(byte_addr(iir_pkg::REG_A1), ROWS[r].a1);
    write_reg(byte_addr(iir_pkg::REG_A2), ROWS[r].a2);
    mx1    = 0;
    mx2    = 0;
    my1    = 0;
    my2    = 0;
    sat_hi = 0;
    sat_lo = 0;
    x0     = '0;
    write_reg(byte_addr(iir_pkg::REG_CTRL), {30'd0, ROWS[r].bypass, 1'b1});
    for (k = 0; k < int'(ROWS[r].count); k++) begin
      wait_valid(2 * int'(ROWS[r].period) + 8, ok);
      if (!ok) begin
        errors++;
        $display("row %0d: no y_valid arrived for sample %0d", r, k);
        break;
      end
      model_sample(r, x0, y_exp);
      check_value(y, y_exp, $sformatf("row %0d sample %0d y", r, k));
      if (y == WAVE_MAX) sat_hi++; // clamped at the top
      if (y == WAVE_MIN) sat_lo++;
      x0 = x0 + step; // sawtooth wraps
    end
    if (ROWS[r].need_sat)
      check_value(sat_hi > 0 && sat_lo > 0, 1, $sformatf("row %0d clamps both ways", r));
    tests++;
    $display("row %0d: step %0d, %0d samples, %0d errors", r, step, k, errors - e0);
  endtask

  task automatic sample_rate();
    logic ok;
    int   pulses;
    int   e0;
    e0 = errors;
    write_reg(byte_addr(iir_pkg::REG_CTRL), 32'd0);
    repeat (10) @(posedge clk);
    write_reg(byte_addr(iir_pkg::REG_PERIOD), 32'd13);
    write_reg(byte_addr(iir_pkg::REG_CTRL), 32'd1);
    wait_valid(40, ok);
    check_value(ok, 1, "first sample at period 13");
    pulses = 0;
    repeat (1300) begin
      @(negedge clk);
      if (y_valid) pulses++;
    end
    check_value(pulses >= 99 && pulses <= 101, 1, $sformatf("%0d pulses in 1300 cycles", pulses));
    tests++;
    $display("sample rate: %0d pulses, %0d errors", pulses, errors - e0);
  endtask

  task automatic disable_stop();
    int pulses;
    int e0;
    e0 = errors;
    write_reg(byte_addr(iir_pkg::REG_CTRL), 32'd0);
    repeat (8) @(posedge clk);
    pulses = 0;
    repeat (130) begin
      @(negedge clk);
      if (y_valid) pulses++;
    end
    check_value(pulses, 0, "y_valid while disabled");
    tests++;
    $display("disable: %0d errors", errors - e0);
  endtask

  ////////////////////////////////////////
  // main sequence and watchdog
  ////////////////////////////////////////
  initial begin
    int r;
    rst     = 1'b1;
    paddr   = '0;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
    pwdata  = '0;
    repeat (16) @(posedge clk);
    rst <= 1'b0;
    @(negedge clk);
    check_value(y_valid, 0, "y_valid after reset");
    check_value(pready, 0, "pready after reset");
    register_access();
    for (r = 0; r < NUM_ROWS; r++)
      run_row(r);
    sample_rate();
    disable_stop();
    run_row(2); // restart from cleared history
    $display("summary: %0d tests, %0d checks, %0d errors", tests, checks, errors);
    if (errors == 0)
      $display("Done: no errors");
    else
      $display("Done: errors found");
    $finish;
  end

  initial begin
    longint limit;
    limit = run_limit();
    #(limit);
    $display("timeout: run did not finish within %0d time units", limit);
    $display("Done: errors found");
    $finish;
  end

endmodule

`default_nettype wire
